// ==== lwe_cfg_pkg.sv ====
`default_nettype none

package lwe_cfg_pkg;

   // lattice dimensions
   // secret length
   parameter int N_DIM = 8;
   // rows of A, one result per row
   parameter int M_ROWS = 8;

   // coefficient arithmetic, modulus 2048 comes from the width
   parameter int COEF_W = 11;
   // half the modulus, encodes a message bit of 1
   parameter int MSG_OFFSET = 1024;

   // shared word memory
   parameter int WORD_W = 32;
   parameter int MEM_DEPTH = 128;
   parameter int ADDR_W = $clog2(MEM_DEPTH);

   // region layout: A row-major, then s, then m, then results
   parameter int A_BASE = 0;
   parameter int S_BASE = 64;
   parameter int M_BASE = 72;
   parameter int B_BASE = 80;
   // words the host sends, A + s + m
   parameter int LOAD_WORDS = 80;

   // flow control start values
   // byte credits the host starts with
   parameter int IN_CREDITS = 4;
   // word credits the streamer starts with
   parameter int OUT_CREDITS = 2;

   typedef logic [COEF_W-1:0] coef_t;
   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [WORD_W-1:0] word_t;

endpackage

`default_nettype wire

// ==== lwe_bus_pkg.sv ====
`default_nettype none

package lwe_bus_pkg;

   import lwe_cfg_pkg::*;

   // one memory access from a peer
   // held steady until the arbiter grants it
   typedef struct packed {
      logic  valid;
      logic  write;
      addr_t addr;
      word_t wdata;
   } mem_req_t;

   // host byte stream, one beat per credit
   typedef struct packed {
      logic       valid;
      logic [7:0] data;
   } byte_beat_t;

   // result word stream toward the host
   typedef struct packed {
      logic  valid;
      word_t data;
   } word_beat_t;

   // one bit per memory peer, highest priority first
   typedef struct packed {
      logic loader;
      logic engine;
      logic streamer;
   } peer_gnt_t;

endpackage

`default_nettype wire

// ==== word_packer.sv ====
`timescale 1ns/100ps
`default_nettype none

module word_packer
   import lwe_cfg_pkg::*;
   import lwe_bus_pkg::*;
#(
   parameter int LOAD_WORDS = lwe_cfg_pkg::LOAD_WORDS
) (
   input wire             clk_100mhz,
   input wire             sys_rst,
   input wire byte_beat_t in_beat,
   output logic           in_credit,
   output mem_req_t       req,
   input wire             gnt,
   output logic           load_done
);

   // small skid buffer, catches bytes while a word waits for memory
   logic [7:0] fifo_data [2];
   logic       fifo_wr_ptr;
   logic       fifo_rd_ptr;
   logic [1:0] fifo_cnt;

   // word assembly, first byte ends up in the low lane
   word_t      shift_word;
   logic [1:0] byte_cnt;

   // pending memory write
   logic       wr_pending;
   addr_t      wr_addr;
   word_t      wr_word;
   logic       all_loaded;

   logic       take;
   logic       push;
   logic       pop;
   logic [7:0] next_byte;

   // consume one byte per cycle unless a finished word still waits
   assign take = (fifo_cnt != 2'd0 || in_beat.valid) && (!wr_pending || gnt) && !all_loaded;
   assign pop = take && fifo_cnt != 2'd0;
   // empty buffer plus immediate take means bypass
   assign push = in_beat.valid && !(take && fifo_cnt == 2'd0);
   // oldest byte first
   assign next_byte = (fifo_cnt != 2'd0) ? fifo_data[fifo_rd_ptr] : in_beat.data;

   assign req = '{valid: wr_pending, write: 1'b1, addr: wr_addr, wdata: wr_word};

   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         fifo_wr_ptr <= 1'b0;
         fifo_rd_ptr <= 1'b0;
         fifo_cnt <= 2'd0;
         byte_cnt <= 2'd0;
         wr_pending <= 1'b0;
         wr_addr <= addr_t'(A_BASE);
         all_loaded <= 1'b0;
         in_credit <= 1'b0;
         load_done <= 1'b0;
      end else begin
         // credit goes back one cycle after the byte is taken
         in_credit <= take;
         load_done <= 1'b0;
         if (push) begin
            fifo_wr_ptr <= !fifo_wr_ptr;
         end
         if (pop) begin
            fifo_rd_ptr <= !fifo_rd_ptr;
         end
         case ({push, pop})
            2'b10: fifo_cnt <= fifo_cnt + 2'd1;
            2'b01: fifo_cnt <= fifo_cnt - 2'd1;
            default: ;
         endcase
         // write accepted, step to next load address
         if (wr_pending && gnt) begin
            wr_pending <= 1'b0;
            wr_addr <= wr_addr + 1'b1;
            if (wr_addr == addr_t'(A_BASE + LOAD_WORDS - 1)) begin
               all_loaded <= 1'b1;
               load_done <= 1'b1;
            end
         end
         if (take) begin
            byte_cnt <= byte_cnt + 2'd1;
            // fourth byte completes the word
            if (byte_cnt == 2'd3) begin
               wr_pending <= 1'b1;
            end
         end
      end
   end

   // data path
   always_ff @(posedge clk_100mhz) begin
      if (push) begin
         fifo_data[fifo_wr_ptr] <= in_beat.data;
      end
      if (take) begin
         shift_word <= {next_byte, shift_word[WORD_W-1:8]};
         if (byte_cnt == 2'd3) begin
            wr_word <= {next_byte, shift_word[WORD_W-1:8]};
         end
      end
   end

   // host credit discipline keeps the buffer within two bytes
   a_fifo_no_overflow: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
      (fifo_cnt == 2'd2 && in_beat.valid) |-> pop);

endmodule

`default_nettype wire

// ==== word_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module word_ram
   import lwe_cfg_pkg::*;
   import lwe_bus_pkg::*;
#(
   parameter int MEM_DEPTH = lwe_cfg_pkg::MEM_DEPTH
) (
   input wire           clk_100mhz,
   input wire mem_req_t mem_req,
   output word_t        rdata
);

   // A, s, m and results all live here
   word_t mem [MEM_DEPTH];

   // single port
   // write and registered read share the address
   always_ff @(posedge clk_100mhz) begin
      if (mem_req.valid) begin
         if (mem_req.write) begin
            mem[mem_req.addr] <= mem_req.wdata;
         end
         // read-first, old contents come back on a write
         rdata <= mem[mem_req.addr];
      end
   end

endmodule

`default_nettype wire

// ==== mem_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter
   import lwe_cfg_pkg::*;
   import lwe_bus_pkg::*;
(
   input wire           clk_100mhz,
   input wire           sys_rst,
   input wire mem_req_t load_req,
   input wire mem_req_t enc_req,
   input wire mem_req_t strm_req,
   output peer_gnt_t    gnt,
   output peer_gnt_t    rvalid,
   output mem_req_t     mem_req
);

   // fixed priority: loader, engine, streamer
   // grant in the same cycle as the request
   always_comb begin
      gnt = '0;
      mem_req = '0;
      if (load_req.valid) begin
         gnt.loader = 1'b1;
         mem_req = load_req;
      end else if (enc_req.valid) begin
         gnt.engine = 1'b1;
         mem_req = enc_req;
      end else if (strm_req.valid) begin
         gnt.streamer = 1'b1;
         mem_req = strm_req;
      end
   end

   // remember whose read comes back next cycle
   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         rvalid <= '0;
      end else begin
         rvalid.loader <= gnt.loader && !load_req.write;
         rvalid.engine <= gnt.engine && !enc_req.write;
         rvalid.streamer <= gnt.streamer && !strm_req.write;
      end
   end

   // a request that lost arbitration stays put until granted
   a_enc_req_held: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
      (enc_req.valid && !gnt.engine) |=> $stable(enc_req));
   a_strm_req_held: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
      (strm_req.valid && !gnt.streamer) |=> $stable(strm_req));

endmodule

`default_nettype wire

// ==== lwe_encrypt_engine.sv ====
`timescale 1ns/100ps
`default_nettype none

module lwe_encrypt_engine
   import lwe_cfg_pkg::*;
   import lwe_bus_pkg::*;
#(
   parameter int N_DIM  = lwe_cfg_pkg::N_DIM,
   parameter int M_ROWS = lwe_cfg_pkg::M_ROWS
) (
   input wire        clk_100mhz,
   input wire        sys_rst,
   input wire        load_done,
   output mem_req_t  req,
   input wire        gnt,
   input wire        rvalid,
   input wire word_t rdata,
   output logic      enc_done
);

   localparam int ROW_W = $clog2(M_ROWS);
   localparam int COL_W = $clog2(N_DIM);

   // REQ states hold a request, WAIT states wait for rvalid
   typedef enum logic [2:0] {
      S_IDLE,
      S_REQ_A,
      S_WAIT_A,
      S_REQ_S,
      S_WAIT_S,
      S_REQ_M,
      S_WAIT_M,
      S_WRITE
   } state_t;

   state_t              state;
   logic [ROW_W-1:0]    row;
   logic [COL_W-1:0]    col;
   // A[i][j] held until s[j] arrives
   coef_t               a_coef;
   // running dot product, wraps mod 2048
   coef_t               acc;
   logic [2*COEF_W-1:0] prod;

   // full product, low bits are the residue
   assign prod = a_coef * rdata[COEF_W-1:0];

   // one request per state, only one read in flight
   always_comb begin
      req = '0;
      case (state)
         S_REQ_A: begin
            req.valid = 1'b1;
            req.addr = addr_t'(A_BASE + row * N_DIM + col);
         end
         S_REQ_S: begin
            req.valid = 1'b1;
            req.addr = addr_t'(S_BASE + col);
         end
         S_REQ_M: begin
            req.valid = 1'b1;
            req.addr = addr_t'(M_BASE + row);
         end
         S_WRITE: begin
            // b_i back into memory, zeros above the coefficient
            req.valid = 1'b1;
            req.write = 1'b1;
            req.addr = addr_t'(B_BASE + row);
            req.wdata = word_t'(acc);
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         state <= S_IDLE;
         row <= '0;
         col <= '0;
         enc_done <= 1'b0;
      end else begin
         enc_done <= 1'b0;
         case (state)
            S_IDLE: begin
               if (load_done) begin
                  row <= '0;
                  col <= '0;
                  state <= S_REQ_A;
               end
            end
            S_REQ_A: if (gnt) state <= S_WAIT_A;
            S_WAIT_A: if (rvalid) state <= S_REQ_S;
            S_REQ_S: if (gnt) state <= S_WAIT_S;
            S_WAIT_S: begin
               if (rvalid) begin
                  // last column done, fetch the message bit
                  if (col == COL_W'(N_DIM - 1)) begin
                     col <= '0;
                     state <= S_REQ_M;
                  end else begin
                     col <= col + 1'b1;
                     state <= S_REQ_A;
                  end
               end
            end
            S_REQ_M: if (gnt) state <= S_WAIT_M;
            S_WAIT_M: if (rvalid) state <= S_WRITE;
            S_WRITE: begin
               if (gnt) begin
                  if (row == ROW_W'(M_ROWS - 1)) begin
                     enc_done <= 1'b1;
                     state <= S_IDLE;
                  end else begin
                     row <= row + 1'b1;
                     state <= S_REQ_A;
                  end
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // arithmetic, masked to the coefficient bits
   always_ff @(posedge clk_100mhz) begin
      case (state)
         S_IDLE: if (load_done) acc <= '0;
         S_WAIT_A: if (rvalid) a_coef <= rdata[COEF_W-1:0];
         S_WAIT_S: if (rvalid) acc <= acc + prod[COEF_W-1:0];
         // message bit 1 adds q/2
         S_WAIT_M: if (rvalid && rdata[0]) acc <= acc + coef_t'(MSG_OFFSET);
         // fresh accumulator for the next row
         S_WRITE: if (gnt) acc <= '0;
         default: ;
      endcase
   end

endmodule

`default_nettype wire

// ==== result_streamer.sv ====
`timescale 1ns/100ps
`default_nettype none

module result_streamer
   import lwe_cfg_pkg::*;
   import lwe_bus_pkg::*;
#(
   parameter int M_ROWS      = lwe_cfg_pkg::M_ROWS,
   parameter int OUT_CREDITS = lwe_cfg_pkg::OUT_CREDITS
) (
   input wire         clk_100mhz,
   input wire         sys_rst,
   input wire         enc_done,
   output mem_req_t   req,
   input wire         gnt,
   input wire         rvalid,
   input wire word_t  rdata,
   output word_beat_t out_beat,
   input wire         out_credit
);

   localparam int CNT_W = $clog2(OUT_CREDITS + 1);
   localparam int IDX_W = $clog2(M_ROWS + 1);

   // words the host can still take
   logic [CNT_W-1:0] credits;
   // results already requested
   logic [IDX_W-1:0] rd_idx;
   logic             running;
   // read issued, beat not yet sent
   logic             in_flight;
   logic             beat_valid;
   word_t            beat_data;

   // read only with a credit in hand and no beat outstanding
   assign req = '{valid: running && !in_flight && credits != '0 && rd_idx != IDX_W'(M_ROWS),
                  write: 1'b0,
                  addr: addr_t'(B_BASE + rd_idx),
                  wdata: '0};

   assign out_beat = '{valid: beat_valid, data: beat_data};

   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         credits <= CNT_W'(OUT_CREDITS);
         rd_idx <= '0;
         running <= 1'b0;
         in_flight <= 1'b0;
         beat_valid <= 1'b0;
      end else begin
         // returned read becomes the next beat
         beat_valid <= rvalid;
         // spend on send, refill on host pulse
         case ({out_credit, beat_valid})
            2'b10: credits <= credits + 1'b1;
            2'b01: credits <= credits - 1'b1;
            default: ;
         endcase
         if (enc_done) begin
            running <= 1'b1;
            rd_idx <= '0;
         end
         if (req.valid && gnt) begin
            in_flight <= 1'b1;
            rd_idx <= rd_idx + 1'b1;
         end
         if (beat_valid) begin
            in_flight <= 1'b0;
            // last row sent
            if (rd_idx == IDX_W'(M_ROWS)) begin
               running <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge clk_100mhz) begin
      if (rvalid) begin
         beat_data <= rdata;
      end
   end

   // credit held at issue must still be there when the beat leaves
   a_beat_has_credit: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
      out_beat.valid |-> credits != '0);

endmodule

`default_nettype wire

// ==== lwe_core_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module lwe_core_top
   import lwe_cfg_pkg::*;
   import lwe_bus_pkg::*;
(
   input wire             clk_100mhz,
   input wire             sys_rst,
   input wire byte_beat_t in_beat,
   output logic           in_credit,
   output word_beat_t     out_beat,
   input wire             out_credit
);

   // per-peer requests and the one that reaches memory
   mem_req_t  load_req;
   mem_req_t  enc_req;
   mem_req_t  strm_req;
   mem_req_t  ram_req;
   peer_gnt_t gnt;
   peer_gnt_t rvalid;
   word_t     rdata;
   // phase handoff
   logic      load_done;
   logic      enc_done;

   // host bytes into A, s, m
   word_packer #(
      .LOAD_WORDS(LOAD_WORDS)
   ) loader (
      .clk_100mhz(clk_100mhz),
      .sys_rst(sys_rst),
      .in_beat(in_beat),
      .in_credit(in_credit),
      .req(load_req),
      .gnt(gnt.loader),
      .load_done(load_done)
   );

   mem_arbiter arbiter (
      .clk_100mhz(clk_100mhz),
      .sys_rst(sys_rst),
      .load_req(load_req),
      .enc_req(enc_req),
      .strm_req(strm_req),
      .gnt(gnt),
      .rvalid(rvalid),
      .mem_req(ram_req)
   );

   word_ram #(
      .MEM_DEPTH(MEM_DEPTH)
   ) ram (
      .clk_100mhz(clk_100mhz),
      .mem_req(ram_req),
      .rdata(rdata)
   );

   // b = A*s + m*q/2
   lwe_encrypt_engine #(
      .N_DIM(N_DIM),
      .M_ROWS(M_ROWS)
   ) engine (
      .clk_100mhz(clk_100mhz),
      .sys_rst(sys_rst),
      .load_done(load_done),
      .req(enc_req),
      .gnt(gnt.engine),
      .rvalid(rvalid.engine),
      .rdata(rdata),
      .enc_done(enc_done)
   );

   result_streamer #(
      .M_ROWS(M_ROWS),
      .OUT_CREDITS(OUT_CREDITS)
   ) streamer (
      .clk_100mhz(clk_100mhz),
      .sys_rst(sys_rst),
      .enc_done(enc_done),
      .req(strm_req),
      .gnt(gnt.streamer),
      .rvalid(rvalid.streamer),
      .rdata(rdata),
      .out_beat(out_beat),
      .out_credit(out_credit)
   );

endmodule

`default_nettype wire

// ==== tb_lwe_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_lwe_core
   import lwe_cfg_pkg::*;
   import lwe_bus_pkg::*;
;

   localparam int RST_CYCLES = 16;
   localparam int QUIET_CYCLES = 200;
   localparam int NUM_CASES = 2;
   // bytes, engine reads and writes, beats, idle tail and reset of one case
   localparam int CASE_OPS = LOAD_WORDS * 4 + M_ROWS * (2 * N_DIM + 2) + M_ROWS
                             + QUIET_CYCLES + RST_CYCLES;
   localparam int TIMEOUT_CYCLES = 20 * NUM_CASES * CASE_OPS;
   localparam logic [31:0] RAND_SEED = 32'hd08e;

   logic       clk_100mhz;
   logic       sys_rst;
   byte_beat_t in_beat;
   logic       in_credit;
   word_beat_t out_beat;
   logic       out_credit = 1'b0;

   // words in load order: A, then s, then m
   word_t load_words [LOAD_WORDS];
   word_t expected [M_ROWS];
   int    beat_cnt;
   int    outstanding;
   int    next_out;
   int    fail_count = 0;
   int    cycle_cnt = 0;
   // credit return timing, changed per case
   int    ret_delay_min;
   int    ret_delay_max;
   int    due_q [$];
   int    now_cycle;

   lwe_core_top uut (
      .clk_100mhz(clk_100mhz),
      .sys_rst(sys_rst),
      .in_beat(in_beat),
      .in_credit(in_credit),
      .out_beat(out_beat),
      .out_credit(out_credit)
   );

   initial begin
      clk_100mhz = 1'b0;
      forever #5 clk_100mhz = ~clk_100mhz;
   end

   // b_i = sum of A[i][j]*s[j] over 11-bit coefficients, plus q/2 for m_i, mod 2048
   function automatic word_t lwe_ref(input word_t words [LOAD_WORDS], input int row);
      logic [31:0] sum;
      sum = '0;
      for (int j = 0; j < N_DIM; j++) begin
         sum = sum + 32'(words[A_BASE + row * N_DIM + j][10:0])
                   * 32'(words[S_BASE + j][10:0]);
      end
      if (words[M_BASE + row][0]) begin
         sum = sum + 32'(MSG_OFFSET);
      end
      return word_t'(sum % 2048);
   endfunction

   task automatic abort_run;
      fail_count = fail_count + 1;
      $display("Test FAILED");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got !== exp) begin
         $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic apply_reset;
      @(posedge clk_100mhz);
      sys_rst <= 1'b1;
      in_beat <= '0;
      repeat (RST_CYCLES) @(posedge clk_100mhz);
      sys_rst <= 1'b0;
   endtask

   // random words, upper bits left random so masking gets exercised
   task automatic build_case(input bit zero_secret);
      for (int k = 0; k < LOAD_WORDS; k++) begin
         load_words[k] = $urandom;
      end
      if (zero_secret) begin
         for (int j = 0; j < N_DIM; j++) begin
            load_words[S_BASE + j] = '0;
         end
      end
      for (int i = 0; i < M_ROWS; i++) begin
         // zero secret leaves only the message term
         if (zero_secret) begin
            expected[i] = load_words[M_BASE + i][0] ? word_t'(MSG_OFFSET) : '0;
         end else begin
            expected[i] = lwe_ref(load_words, i);
         end
      end
   endtask

   // host side of the byte stream, own credit count
   task automatic send_load(input int max_gap);
      int         idx;
      int         gap;
      int         host_credits;
      logic [7:0] next_byte;
      idx = 0;
      gap = 0;
      host_credits = IN_CREDITS;
      while (idx < LOAD_WORDS * 4) begin
         @(posedge clk_100mhz);
         if (in_credit) begin
            host_credits = host_credits + 1;
         end
         if (host_credits > IN_CREDITS) begin
            $display("host got back more byte credits than it spent");
            abort_run();
         end
         if (gap == 0 && host_credits > 0) begin
            // least significant byte of each word first
            next_byte = load_words[idx / 4][8 * (idx % 4) +: 8];
            in_beat <= '{valid: 1'b1, data: next_byte};
            host_credits = host_credits - 1;
            idx = idx + 1;
            // mostly back-to-back bursts, sometimes a pause
            gap = ($urandom_range(3, 0) == 0) ? $urandom_range(max_gap, 1) : 0;
         end else begin
            in_beat <= '0;
            if (gap > 0) begin
               gap = gap - 1;
            end
         end
      end
      @(posedge clk_100mhz);
      in_beat <= '0;
   endtask

   task automatic wait_results;
      while (beat_cnt < M_ROWS) begin
         @(posedge clk_100mhz);
      end
      // any surplus beat in this window still counts
      repeat (QUIET_CYCLES) @(posedge clk_100mhz);
      check_count("result beat count", beat_cnt, M_ROWS);
   endtask

   // result monitor and compare
   always @(posedge clk_100mhz) begin
      if (sys_rst) begin
         beat_cnt <= 0;
         outstanding <= 0;
      end else begin
         next_out = outstanding + int'(out_beat.valid) - int'(out_credit);
         if (out_beat.valid) begin
            // beats past the last row are only counted
            if (beat_cnt < M_ROWS) begin
               check_word("out_beat.data", out_beat.data, expected[beat_cnt]);
            end
            beat_cnt <= beat_cnt + 1;
         end
         if (next_out > OUT_CREDITS) begin
            $display("more result words outstanding than the %0d output credits", OUT_CREDITS);
            abort_run();
         end
         outstanding <= next_out;
      end
   end

   // host consumes words late, one credit pulse per cycle at most
   always @(posedge clk_100mhz) begin
      if (sys_rst) begin
         due_q.delete();
         now_cycle = 0;
         out_credit <= 1'b0;
      end else begin
         now_cycle = now_cycle + 1;
         if (out_beat.valid) begin
            due_q.push_back(now_cycle + $urandom_range(ret_delay_max, ret_delay_min));
         end
         if (due_q.size() > 0 && due_q[0] <= now_cycle) begin
            void'(due_q.pop_front());
            out_credit <= 1'b1;
         end else begin
            out_credit <= 1'b0;
         end
      end
   end

   // watchdog
   always @(posedge clk_100mhz) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt > TIMEOUT_CYCLES) begin
         $display("timeout: results did not arrive within %0d cycles", TIMEOUT_CYCLES);
         abort_run();
      end
   end

   initial begin
      void'($urandom(RAND_SEED));
      sys_rst = 1'b1;
      in_beat = '0;
      // random A, s, m, quick credit return
      ret_delay_min = 1;
      ret_delay_max = 4;
      build_case(1'b0);
      apply_reset();
      send_load(6);
      wait_results();
      // zero secret, slow credit return, denser bursts
      ret_delay_min = 20;
      ret_delay_max = 40;
      build_case(1'b1);
      apply_reset();
      send_load(2);
      wait_results();
      if (fail_count == 0) begin
         $display("Test OK");
         $finish;
      end else begin
         $display("Test FAILED");
         $fatal(1, "errors were counted");
      end
   end

endmodule

`default_nettype wire

// ==== sources.f ====
lwe_cfg_pkg.sv
lwe_bus_pkg.sv
word_packer.sv
word_ram.sv
mem_arbiter.sv
lwe_encrypt_engine.sv
result_streamer.sv
lwe_core_top.sv
tb_lwe_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_lwe_core \
   -f sources.f -o sim_lwe_core || exit 1
sim_out=$(./obj_dir/sim_lwe_core 2>&1)
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -qx "Test OK" && exit 0 || exit 1
